// File: all.f
+incdir+tests
source/fp_ss_pkg.sv
source/fp_decoder.sv
source/fp_classifier.sv
source/fp_noncomp_unit.sv
source/fp_pipe.sv
source/fp_ss.sv
tests/tb_fp_ss.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FP subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_fp_ss -Mdir build

./build/Vtb_fp_ss | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
else
  exit 1
fi

// File: tests/fp_ss_model.svh
/*
 * Reference model for the FP subsystem testbench: OP-FP decode rules,
 * expected responses and a linear congruential generator
 */
`ifndef FP_SS_MODEL_SVH
`define FP_SS_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// RISC-V class mask, bit 0 is -inf and bit 9 is quiet NaN
function automatic logic [9:0] model_class(input logic [31:0] v, input bit is_h);
  bit          sign;
  logic [7:0]  exp_v;
  logic [7:0]  exp_max;
  logic [22:0] man;
  sign    = is_h ? v[15] : v[31];
  exp_v   = is_h ? {3'b0, v[14:10]} : v[30:23];
  exp_max = is_h ? 8'd31 : 8'd255;
  // H mantissa left aligned so bit 22 is the quiet bit
  man     = is_h ? {v[9:0], 13'b0} : v[22:0];
  if (exp_v == exp_max) begin
    if (man == '0) return sign ? 10'b00_0000_0001 : 10'b00_1000_0000;
    return man[22] ? 10'b10_0000_0000 : 10'b01_0000_0000;
  end
  if (exp_v == '0) begin
    if (man == '0) return sign ? 10'b00_0000_1000 : 10'b00_0001_0000;
    return sign ? 10'b00_0000_0100 : 10'b00_0010_0000;
  end
  return sign ? 10'b00_0000_0010 : 10'b00_0100_0000;
endfunction

// Unsigned key in numeric order, both zeros share one key
function automatic logic [31:0] order_key(input logic [31:0] v, input bit is_h);
  logic [31:0] mag;
  bit          sign;
  mag  = is_h ? {17'b0, v[14:0]} : {1'b0, v[30:0]};
  sign = is_h ? v[15] : v[31];
  return sign ? 32'h8000_0000 - mag : 32'h8000_0000 + mag;
endfunction

function automatic fp_ss_pkg::acc_resp_t model_resp(input fp_ss_pkg::acc_req_t req,
                                                    output bit legal);
  fp_ss_pkg::acc_resp_t resp;
  logic [31:0]          op;
  logic [31:0]          a;
  logic [31:0]          b;
  logic [4:0]           funct5;
  logic [2:0]           rm;
  logic [9:0]           cls_a;
  logic [9:0]           cls_b;
  bit                   is_h;
  bit                   sign_a;
  bit                   sign_b;
  bit                   new_sign;
  bit                   a_first;
  op     = req.data_op;
  funct5 = op[31:27];
  rm     = op[14:12];
  is_h   = (op[26:25] == 2'b10);
  legal  = (op[6:0] == fp_ss_pkg::OPC_OP_FP) && (op[26:25] == 2'b00 || is_h);
  case (funct5)
    fp_ss_pkg::FUNCT5_SGNJ:   legal = legal && (rm <= 3'd2);
    fp_ss_pkg::FUNCT5_MINMAX: legal = legal && (rm <= 3'd1);
    fp_ss_pkg::FUNCT5_CMP:    legal = legal && (rm <= 3'd2);
    fp_ss_pkg::FUNCT5_CLASS:  legal = legal && (rm == 3'd1) && (op[24:20] == 5'd0);
    default:                  legal = 1'b0;
  endcase
  resp.id    = op[11:7];
  resp.error = !legal;
  resp.data  = '0;
  if (!legal) return resp;

  // H operands are viewed NaN-boxed
  a      = is_h ? {16'hffff, req.data_arga[15:0]} : req.data_arga;
  b      = is_h ? {16'hffff, req.data_argb[15:0]} : req.data_argb;
  cls_a  = model_class(a, is_h);
  cls_b  = model_class(b, is_h);
  sign_a = is_h ? a[15] : a[31];
  sign_b = is_h ? b[15] : b[31];
  case (funct5)
    fp_ss_pkg::FUNCT5_SGNJ: begin
      if (rm == 3'd0) new_sign = sign_b;
      else if (rm == 3'd1) new_sign = !sign_b;
      else new_sign = sign_a ^ sign_b;
      resp.data = a;
      if (is_h) resp.data[15] = new_sign;
      else resp.data[31] = new_sign;
    end
    fp_ss_pkg::FUNCT5_MINMAX: begin
      a_first = (order_key(a, is_h) < order_key(b, is_h)) ||
                ((order_key(a, is_h) == order_key(b, is_h)) && sign_a);
      if ((|cls_a[9:8]) && (|cls_b[9:8]))
        resp.data = is_h ? {16'hffff, fp_ss_pkg::CANON_NAN_H} : fp_ss_pkg::CANON_NAN_S;
      else if (|cls_a[9:8]) resp.data = b;
      else if (|cls_b[9:8]) resp.data = a;
      else resp.data = (a_first ^ rm[0]) ? a : b;
    end
    fp_ss_pkg::FUNCT5_CMP: begin
      if (rm == 3'd0) resp.data[0] = order_key(a, is_h) <= order_key(b, is_h);
      else if (rm == 3'd1) resp.data[0] = order_key(a, is_h) < order_key(b, is_h);
      else resp.data[0] = order_key(a, is_h) == order_key(b, is_h);
      if ((|cls_a[9:8]) || (|cls_b[9:8])) resp.data = '0;
    end
    default: resp.data = {22'b0, cls_a};
  endcase
  return resp;
endfunction

`endif

// File: tests/tb_fp_ss.sv
/*
 * Testbench for the FP subsystem: random OP-FP requests under back-pressure
 * checked against a reference model, then a full-throughput burst
 */
`timescale 1ns/1ns

module tb_fp_ss;

  localparam int unsigned NUM_REQ    = 2000;
  localparam int unsigned BURST_REQ  = 200;
  localparam int unsigned CLK_PERIOD = 4;

  // S specials first, then H specials in the low half
  localparam logic [31:0] SPECIALS [20] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
    32'h7fa0_0001, 32'h0000_0001, 32'h807f_ffff, 32'h3f80_0000, 32'hbf80_0000,
    32'h0000_0000, 32'h0000_8000, 32'h0000_7c00, 32'h0000_fc00, 32'h0000_7e00,
    32'h0000_7d01, 32'h0000_0001, 32'h0000_83ff, 32'h0000_3c00, 32'h0000_bc00};

  logic                    clk_i;
  logic                    arst_n_i;
  fp_ss_pkg::acc_req_t     acc_req_i;
  logic                    acc_req_valid_i;
  logic                    acc_req_ready_o;
  fp_ss_pkg::acc_resp_t    acc_resp_o;
  logic                    acc_resp_valid_o;
  logic                    acc_resp_ready_i;
  fp_ss_pkg::core_events_t core_events_o;

  logic [31:0]          rng_state;
  fp_ss_pkg::acc_resp_t exp_q [$];
  int unsigned          accept_q [$];
  bit                   timed_q [$];
  int unsigned          value_errs;
  int unsigned          latency_errs;
  int unsigned          event_errs;
  int unsigned          order_errs;
  int unsigned          flow_errs;

  `include "fp_ss_model.svh"

  fp_ss dut_i (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .acc_req_i        ( acc_req_i        ),
    .acc_req_valid_i  ( acc_req_valid_i  ),
    .acc_req_ready_o  ( acc_req_ready_o  ),
    .acc_resp_o       ( acc_resp_o       ),
    .acc_resp_valid_o ( acc_resp_valid_o ),
    .acc_resp_ready_i ( acc_resp_ready_i ),
    .core_events_o    ( core_events_o    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] draw();
    logic [31:0] hi;
    rng_state = lcg_next(rng_state);
    hi        = rng_state;
    rng_state = lcg_next(rng_state);
    return {hi[31:16], rng_state[31:16]};
  endfunction

  function automatic logic [31:0] draw_operand();
    logic [31:0] r;
    int unsigned idx;
    r   = draw();
    idx = r[15:8] % 20;
    if (r[0]) return draw();
    return (idx >= 10) ? {r[31:16], SPECIALS[idx][15:0]} : SPECIALS[idx];
  endfunction

  function automatic logic [31:0] draw_instr();
    logic [31:0] r;
    logic [4:0]  funct5;
    logic [4:0]  rs2;
    logic [2:0]  rm;
    int unsigned idx;
    if (draw() % 10 == 0) return draw();
    r   = draw();
    idx = r[23:16] % 9;
    rs2 = r[4:0];
    rm  = 3'd1;
    if (idx < 3) begin
      funct5 = fp_ss_pkg::FUNCT5_SGNJ;
      rm     = 3'(idx);
    end else if (idx < 5) begin
      funct5 = fp_ss_pkg::FUNCT5_MINMAX;
      rm     = 3'(idx - 3);
    end else if (idx < 8) begin
      funct5 = fp_ss_pkg::FUNCT5_CMP;
      rm     = 3'(idx - 5);
    end else begin
      funct5 = fp_ss_pkg::FUNCT5_CLASS;
      rs2    = 5'd0;
    end
    return {funct5, r[5] ? 2'b10 : 2'b00, rs2, r[10:6], rm, r[15:11], fp_ss_pkg::OPC_OP_FP};
  endfunction

  task automatic check_response(input int unsigned cycle);
    fp_ss_pkg::acc_resp_t exp_resp;
    int unsigned          accept_cycle;
    bit                   timed;
    if (exp_q.size() == 0) begin
      order_errs++;
      $display("Response at %0t arrived with no request outstanding", $time);
      return;
    end
    exp_resp     = exp_q.pop_front();
    accept_cycle = accept_q.pop_front();
    timed        = timed_q.pop_front();
    assert (acc_resp_o === exp_resp) else begin
      value_errs++;
      $display("Fail at %0t: acc_resp_o expected %h got %h", $time, exp_resp, acc_resp_o);
    end
    if (timed) begin
      assert (cycle - accept_cycle == fp_ss_pkg::PIPE_DEPTH) else begin
        latency_errs++;
        $display("Fail at %0t: response latency expected %0d got %0d", $time,
                 fp_ss_pkg::PIPE_DEPTH, cycle - accept_cycle);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    fp_ss_pkg::acc_resp_t exp_resp;
    int unsigned          sent;
    int unsigned          cycle;
    int unsigned          core_cnt;
    int unsigned          fpu_cnt;
    int unsigned          exp_fpu_cnt;
    bit                   req_fire;
    bit                   legal;
    bit                   burst;
    bit                   exp_ready;
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    rng_state        = 32'd66250;
    {value_errs, latency_errs, event_errs, order_errs, flow_errs} = '0;
    {sent, cycle, core_cnt, fpu_cnt, exp_fpu_cnt} = '0;
    req_fire = 1'b0;
    legal    = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    assert (acc_req_ready_o && !acc_resp_valid_o && core_events_o == '0) else begin
      event_errs++;
      $display("Outputs are not in their reset state after reset release");
    end

    while (sent < NUM_REQ || exp_q.size() != 0) begin
      @(negedge clk_i);
      burst = (sent >= NUM_REQ - BURST_REQ);
      // A waiting request stays unchanged until accepted
      if (!acc_req_valid_i || req_fire) begin
        acc_req_valid_i     = (sent < NUM_REQ) && (burst || draw() % 100 < 70);
        acc_req_i.data_op   = draw_instr();
        acc_req_i.data_arga = draw_operand();
        acc_req_i.data_argb = draw_operand();
      end
      acc_resp_ready_i = burst || (draw() % 100 >= 25);
      #1;
      cycle++;
      // Strobes follow the previous handshake
      assert (core_events_o.issue_core_to_fpu == req_fire &&
              core_events_o.issue_fpu == (req_fire && legal)) else begin
        event_errs++;
        $display("Fail at %0t: core_events_o expected %b got %b", $time,
                 {req_fire && legal, req_fire}, core_events_o);
      end
      if (core_events_o.issue_core_to_fpu) core_cnt++;
      if (core_events_o.issue_fpu) fpu_cnt++;
      // Pipe takes a request unless it is full and its output stalls
      exp_ready = (exp_q.size() < fp_ss_pkg::PIPE_DEPTH) || acc_resp_ready_i;
      assert (acc_req_ready_o == exp_ready) else begin
        flow_errs++;
        $display("Fail at %0t: acc_req_ready_o expected %b got %b", $time,
                 exp_ready, acc_req_ready_o);
      end
      req_fire = acc_req_valid_i && acc_req_ready_o;
      if (acc_resp_valid_o && acc_resp_ready_i) check_response(cycle);
      if (req_fire) begin
        exp_resp = model_resp(acc_req_i, legal);
        exp_q.push_back(exp_resp);
        accept_q.push_back(cycle);
        timed_q.push_back(burst);
        sent++;
        if (legal) exp_fpu_cnt++;
      end
    end

    repeat (fp_ss_pkg::PIPE_DEPTH + 1) begin
      @(negedge clk_i);
      #1;
      assert (!acc_resp_valid_o) else begin
        order_errs++;
        $display("An extra response appeared after all requests were answered");
      end
    end
    assert (core_cnt == NUM_REQ && fpu_cnt == exp_fpu_cnt) else begin
      event_errs++;
      $display("Fail at %0t: strobe counts expected %0d/%0d got %0d/%0d", $time,
               NUM_REQ, exp_fpu_cnt, core_cnt, fpu_cnt);
    end
    $display("Errors: %0d value, %0d latency, %0d event, %0d order, %0d flow",
             value_errs, latency_errs, event_errs, order_errs, flow_errs);
    if (value_errs + latency_errs + event_errs + order_errs + flow_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog allows eight cycles per request
  initial begin
    #(NUM_REQ * 8 * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d ns", NUM_REQ * 8 * CLK_PERIOD);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: source/fp_ss.sv
/*
 * FP subsystem top: accelerator request/response shell around the decoder,
 * the non-computational unit and the result pipeline, plus core event strobes
 */
`timescale 1ns/1ns

module fp_ss (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Accelerator request
  input  fp_ss_pkg::acc_req_t     acc_req_i,
  input  logic                    acc_req_valid_i,
  output logic                    acc_req_ready_o,
  // Accelerator response
  output fp_ss_pkg::acc_resp_t    acc_resp_o,
  output logic                    acc_resp_valid_o,
  input  logic                    acc_resp_ready_i,
  // Core event strobes
  output fp_ss_pkg::core_events_t core_events_o
);

  fp_ss_pkg::fp_uop_t       uop;
  fp_ss_pkg::fp_pipe_data_t unit_data;
  fp_ss_pkg::fp_pipe_data_t pipe_out;
  fp_ss_pkg::core_events_t  events_q;
  logic                     req_hs;

  // --------------------------------------------------------------------------
  // Decode and execute
  // --------------------------------------------------------------------------
  fp_decoder i_decoder (
    .data_op_i ( acc_req_i.data_op ),
    .uop_o     ( uop               )
  );

  fp_noncomp_unit i_unit (
    .uop_i  ( uop                 ),
    .arga_i ( acc_req_i.data_arga ),
    .argb_i ( acc_req_i.data_argb ),
    .data_o ( unit_data           )
  );

  fp_pipe i_pipe (
    .clk_i       ( clk_i            ),
    .arst_n_i    ( arst_n_i         ),
    .in_valid_i  ( acc_req_valid_i  ),
    .in_ready_o  ( acc_req_ready_o  ),
    .in_data_i   ( unit_data        ),
    .out_valid_o ( acc_resp_valid_o ),
    .out_ready_i ( acc_resp_ready_i ),
    .out_data_o  ( pipe_out         )
  );

  // Response tagged with the destination register
  assign acc_resp_o.id    = pipe_out.rd;
  assign acc_resp_o.data  = pipe_out.result;
  assign acc_resp_o.error = pipe_out.error;

  // --------------------------------------------------------------------------
  // Event strobes
  // --------------------------------------------------------------------------
  assign req_hs = acc_req_valid_i & acc_req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      events_q <= '0;
    end else begin
      events_q.issue_core_to_fpu <= req_hs;
      events_q.issue_fpu         <= req_hs & ~uop.illegal;
    end
  end

  assign core_events_o = events_q;

  // Request must hold until accepted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    acc_req_valid_i && !acc_req_ready_o |=> acc_req_valid_i && $stable(acc_req_i))
    else $error("fp_ss: request dropped or changed before ready");

endmodule

// File: source/fp_pipe.sv
/*
 * Elastic register pipeline of PIPE_DEPTH stages with valid/ready flow
 */
`timescale 1ns/1ns

module fp_pipe (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  fp_ss_pkg::fp_pipe_data_t in_data_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output fp_ss_pkg::fp_pipe_data_t out_data_o
);

  localparam int unsigned Depth = fp_ss_pkg::PIPE_DEPTH;

  logic [Depth-1:0]         valid_q;
  logic [Depth-1:0]         stage_ready;
  logic [Depth-1:0]         stage_valid;
  fp_ss_pkg::fp_pipe_data_t data_q     [Depth];
  fp_ss_pkg::fp_pipe_data_t stage_data [Depth];

  // Stage 0 is fed from outside
  always_comb begin
    stage_valid[0] = in_valid_i;
    stage_data[0]  = in_data_i;
    for (int i = 1; i < Depth; i++) begin
      stage_valid[i] = valid_q[i-1];
      stage_data[i]  = data_q[i-1];
    end
  end

  // A stage loads when empty or when its content moves on
  always_comb begin
    logic ready_acc;
    ready_acc = out_ready_i;
    for (int i = Depth - 1; i >= 0; i--) begin
      ready_acc      = ready_acc | ~valid_q[i];
      stage_ready[i] = ready_acc;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < Depth; i++) begin
        if (stage_ready[i]) valid_q[i] <= stage_valid[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < Depth; i++) begin
      if (stage_ready[i] && stage_valid[i]) data_q[i] <= stage_data[i];
    end
  end

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = valid_q[Depth-1];
  assign out_data_o  = data_q[Depth-1];

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("fp_pipe: output changed while stalled");

endmodule

// File: source/fp_noncomp_unit.sv
/*
 * Non-computational FP unit: sign injection, min/max, compares and
 * classify on two S or H operands, fully combinational
 */
`timescale 1ns/1ns

module fp_noncomp_unit (
  input  fp_ss_pkg::fp_uop_t         uop_i,
  input  logic [fp_ss_pkg::FLEN-1:0] arga_i,
  input  logic [fp_ss_pkg::FLEN-1:0] argb_i,
  output fp_ss_pkg::fp_pipe_data_t   data_o
);

  fp_ss_pkg::fp_class_t class_a;
  fp_ss_pkg::fp_class_t class_b;

  logic                       is_h;
  logic [30:0]                mag_a;
  logic [30:0]                mag_b;
  logic [fp_ss_pkg::FLEN-1:0] box_a;
  logic [fp_ss_pkg::FLEN-1:0] box_b;
  logic [fp_ss_pkg::FLEN-1:0] canon_nan;
  logic                       nan_a;
  logic                       nan_b;
  logic                       both_zero;
  logic                       a_lt_b;
  logic                       a_eq_b;
  logic                       sgnj_sign;
  logic                       pick_a;
  logic [fp_ss_pkg::FLEN-1:0] sgnj_res;
  logic [fp_ss_pkg::FLEN-1:0] minmax_res;
  logic                       cmp_bit;
  logic [9:0]                 class_mask;

  fp_classifier i_class_a (
    .operand_i ( arga_i    ),
    .fmt_i     ( uop_i.fmt ),
    .class_o   ( class_a   )
  );

  fp_classifier i_class_b (
    .operand_i ( argb_i    ),
    .fmt_i     ( uop_i.fmt ),
    .class_o   ( class_b   )
  );

  assign is_h = (uop_i.fmt == fp_ss_pkg::FMT_H);

  // Magnitudes without sign, H zero-extended
  assign mag_a = is_h ? {16'b0, arga_i[14:0]} : arga_i[30:0];
  assign mag_b = is_h ? {16'b0, argb_i[14:0]} : argb_i[30:0];

  // NaN-boxed views of the operands
  assign box_a     = is_h ? {16'hffff, arga_i[15:0]} : arga_i;
  assign box_b     = is_h ? {16'hffff, argb_i[15:0]} : argb_i;
  assign canon_nan = is_h ? {16'hffff, fp_ss_pkg::CANON_NAN_H} : fp_ss_pkg::CANON_NAN_S;

  assign nan_a     = class_a.is_snan | class_a.is_qnan;
  assign nan_b     = class_b.is_snan | class_b.is_qnan;
  assign both_zero = class_a.is_zero & class_b.is_zero;

  // Total order, -0 below +0
  assign a_lt_b = (class_a.sign != class_b.sign) ? class_a.sign :
                  class_a.sign ? (mag_b < mag_a) : (mag_a < mag_b);
  assign a_eq_b = both_zero | ((class_a.sign == class_b.sign) && (mag_a == mag_b));

  // --------------------------------------------------------------------------
  // Sub-operation results
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (uop_i.sub[1:0])
      2'd0:    sgnj_sign = class_b.sign;
      2'd1:    sgnj_sign = ~class_b.sign;
      default: sgnj_sign = class_a.sign ^ class_b.sign;
    endcase
  end

  assign sgnj_res = is_h ? {16'hffff, sgnj_sign, arga_i[14:0]} : {sgnj_sign, arga_i[30:0]};

  // sub 0 is min, sub 1 is max
  assign pick_a = uop_i.sub[0] ? ~a_lt_b : a_lt_b;

  always_comb begin
    if (nan_a && nan_b) begin
      minmax_res = canon_nan;
    end else if (nan_a) begin
      minmax_res = box_b;
    end else if (nan_b) begin
      minmax_res = box_a;
    end else begin
      minmax_res = pick_a ? box_a : box_b;
    end
  end

  always_comb begin
    unique case (uop_i.sub[1:0])
      2'd0:    cmp_bit = (a_lt_b & ~both_zero) | a_eq_b;
      2'd1:    cmp_bit = a_lt_b & ~both_zero;
      default: cmp_bit = a_eq_b;
    endcase
    if (nan_a || nan_b) cmp_bit = 1'b0;
  end

  assign class_mask = {class_a.is_qnan,
                       class_a.is_snan,
                       ~class_a.sign & class_a.is_inf,
                       ~class_a.sign & class_a.is_normal,
                       ~class_a.sign & class_a.is_sub,
                       ~class_a.sign & class_a.is_zero,
                       class_a.sign & class_a.is_zero,
                       class_a.sign & class_a.is_sub,
                       class_a.sign & class_a.is_normal,
                       class_a.sign & class_a.is_inf};

  always_comb begin
    data_o.rd    = uop_i.rd;
    data_o.error = uop_i.illegal;
    unique case (uop_i.op)
      fp_ss_pkg::OP_SGNJ:   data_o.result = sgnj_res;
      fp_ss_pkg::OP_MINMAX: data_o.result = minmax_res;
      fp_ss_pkg::OP_CMP:    data_o.result = {31'b0, cmp_bit};
      default:              data_o.result = {22'b0, class_mask};
    endcase
    if (uop_i.illegal) data_o.result = '0;
  end

endmodule

// File: source/fp_classifier.sv
/*
 * Operand classifier: sign plus exactly one class flag for an S or H value
 */
`timescale 1ns/1ns

module fp_classifier (
  input  logic [fp_ss_pkg::FLEN-1:0] operand_i,
  input  fp_ss_pkg::fp_fmt_e         fmt_i,
  output fp_ss_pkg::fp_class_t       class_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;
  logic man_msb;

  always_comb begin
    if (fmt_i == fp_ss_pkg::FMT_H) begin
      // Upper half is ignored for H
      class_o.sign = operand_i[15];
      exp_zero     = (operand_i[14:10] == '0);
      exp_ones     = &operand_i[14:10];
      man_zero     = (operand_i[9:0] == '0);
      man_msb      = operand_i[9];
    end else begin
      class_o.sign = operand_i[31];
      exp_zero     = (operand_i[30:23] == '0);
      exp_ones     = &operand_i[30:23];
      man_zero     = (operand_i[22:0] == '0);
      man_msb      = operand_i[22];
    end

    class_o.is_zero   = exp_zero & man_zero;
    class_o.is_sub    = exp_zero & ~man_zero;
    class_o.is_normal = ~exp_zero & ~exp_ones;
    class_o.is_inf    = exp_ones & man_zero;
    class_o.is_snan   = exp_ones & ~man_zero & ~man_msb;
    class_o.is_qnan   = exp_ones & man_msb;

    if (!$isunknown(operand_i)) begin
      assert ($onehot({class_o.is_zero, class_o.is_sub, class_o.is_normal,
                       class_o.is_inf, class_o.is_snan, class_o.is_qnan}))
        else $error("fp_classifier: class flags not one-hot for %h", operand_i);
    end
  end

endmodule

// File: source/fp_decoder.sv
/*
 * FP instruction decoder: turns an OP-FP word into a micro-op and flags
 * every encoding the non-computational unit does not implement
 */
`timescale 1ns/1ns

module fp_decoder (
  input  logic [fp_ss_pkg::FLEN-1:0] data_op_i,
  output fp_ss_pkg::fp_uop_t         uop_o
);

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic [1:0] fmt_bits;
  logic [4:0] rs2;
  logic [2:0] sub;
  logic       fmt_ok;
  logic       funct_ok;

  assign opcode   = data_op_i[6:0];
  assign funct5   = data_op_i[31:27];
  assign fmt_bits = data_op_i[26:25];
  assign rs2      = data_op_i[24:20];
  assign sub      = data_op_i[14:12];

  // Only S (00) and H (10) are supported
  assign fmt_ok = (fmt_bits == 2'b00) || (fmt_bits == 2'b10);

  always_comb begin
    uop_o.rd  = data_op_i[11:7];
    uop_o.sub = sub;
    uop_o.fmt = (fmt_bits == 2'b10) ? fp_ss_pkg::FMT_H : fp_ss_pkg::FMT_S;

    unique case (funct5)
      fp_ss_pkg::FUNCT5_SGNJ: begin
        uop_o.op = fp_ss_pkg::OP_SGNJ;
        funct_ok = (sub <= 3'd2);
      end
      fp_ss_pkg::FUNCT5_MINMAX: begin
        uop_o.op = fp_ss_pkg::OP_MINMAX;
        funct_ok = (sub <= 3'd1);
      end
      fp_ss_pkg::FUNCT5_CMP: begin
        uop_o.op = fp_ss_pkg::OP_CMP;
        funct_ok = (sub <= 3'd2);
      end
      fp_ss_pkg::FUNCT5_CLASS: begin
        // FCLASS is a single-operand encoding, rs2 must be zero
        uop_o.op = fp_ss_pkg::OP_CLASS;
        funct_ok = (sub == 3'd1) && (rs2 == 5'd0);
      end
      default: begin
        uop_o.op = fp_ss_pkg::OP_SGNJ;
        funct_ok = 1'b0;
      end
    endcase

    uop_o.illegal = !((opcode == fp_ss_pkg::OPC_OP_FP) && fmt_ok && funct_ok);

    if (!$isunknown(data_op_i)) begin
      assert (!$isunknown(uop_o))
        else $error("fp_decoder: unknown bits in uop_o for op %h", data_op_i);
    end
  end

endmodule

// File: source/fp_ss_pkg.sv
/*
 * FP subsystem package: widths, instruction fields, micro-op encodings
 * and the packed structs shared by the request/response shell
 */
package fp_ss_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned FLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned PIPE_DEPTH = 2;

  // --------------------------------------------------------------------------
  // Instruction fields
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPC_OP_FP     = 7'b1010011;

  // Upper five bits of funct7
  localparam logic [4:0] FUNCT5_SGNJ   = 5'b00100;
  localparam logic [4:0] FUNCT5_MINMAX = 5'b00101;
  localparam logic [4:0] FUNCT5_CMP    = 5'b10100;
  localparam logic [4:0] FUNCT5_CLASS  = 5'b11100;

  // Canonical quiet NaNs
  localparam logic [31:0] CANON_NAN_S = 32'h7fc0_0000;
  localparam logic [15:0] CANON_NAN_H = 16'h7e00;

  typedef enum logic [1:0] {
    OP_SGNJ   = 2'd0,
    OP_MINMAX = 2'd1,
    OP_CMP    = 2'd2,
    OP_CLASS  = 2'd3
  } fp_op_e;

  typedef enum logic {
    FMT_S = 1'b0,
    FMT_H = 1'b1
  } fp_fmt_e;

  // --------------------------------------------------------------------------
  // Structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [FLEN-1:0] data_op;
    logic [FLEN-1:0] data_arga;
    logic [FLEN-1:0] data_argb;
  } acc_req_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] id;
    logic [FLEN-1:0]       data;
    logic                  error;
  } acc_resp_t;

  // Decoded instruction, sub is the rm field
  typedef struct packed {
    fp_op_e                op;
    fp_fmt_e               fmt;
    logic [2:0]            sub;
    logic [REG_ADDR_W-1:0] rd;
    logic                  illegal;
  } fp_uop_t;

  typedef struct packed {
    logic sign;
    logic is_zero;
    logic is_sub;
    logic is_normal;
    logic is_inf;
    logic is_snan;
    logic is_qnan;
  } fp_class_t;

  typedef struct packed {
    logic [FLEN-1:0]       result;
    logic [REG_ADDR_W-1:0] rd;
    logic                  error;
  } fp_pipe_data_t;

  typedef struct packed {
    logic issue_fpu;
    logic issue_core_to_fpu;
  } core_events_t;

endpackage
